// File: Makefile
SOURCES = common/cpu_pkg.sv datapath/regfile.sv datapath/alu.sv datapath/datapath.sv \
          verilog/instr_decoder.sv verilog/sequencer.sv verilog/fetch_unit.sv \
          verilog/unified_ram.sv verilog/cpu_top.sv tb/cpu_tb.sv tb/ref_model.svh

obj_dir/Vcpu_tb: project.f $(SOURCES)
	verilator --binary --top-module cpu_tb -f project.f

.PHONY: run clean

run: obj_dir/Vcpu_tb
	result=$$(./obj_dir/Vcpu_tb); \
	echo "$$result"; \
	echo "$$result" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

// File: common/cpu_pkg.sv
package cpu_pkg;

  localparam int WORD_W = 16;
  localparam int ADDR_W = 8;
  localparam int REG_W  = 3;
  localparam int OPC_W  = 3;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [REG_W-1:0]  reg_idx_t;
  typedef logic [1:0]        alu_op_t;
  typedef logic [1:0]        shift_op_t;
  typedef logic [1:0]        reg_sel_t;
  typedef logic [1:0]        wb_sel_t;

  localparam logic [OPC_W-1:0] OPC_MOV  = 3'b110;
  localparam logic [OPC_W-1:0] OPC_ALU  = 3'b101;
  localparam logic [OPC_W-1:0] OPC_LDR  = 3'b011;
  localparam logic [OPC_W-1:0] OPC_STR  = 3'b100;
  localparam logic [OPC_W-1:0] OPC_HALT = 3'b111;

  localparam alu_op_t   ALU_ADD    = 2'b00;
  localparam alu_op_t   ALU_AND    = 2'b10;
  localparam alu_op_t   ALU_NOT    = 2'b11;
  localparam alu_op_t   OP_MOV_IMM = 2'b10; // op field of MOV Rn,#imm8

  localparam shift_op_t SH_NONE = 2'b00;
  localparam shift_op_t SH_LSL  = 2'b01;
  localparam shift_op_t SH_LSR  = 2'b10;
  localparam shift_op_t SH_ASR  = 2'b11;

  localparam reg_sel_t  REG_RM = 2'b00;
  localparam reg_sel_t  REG_RD = 2'b01;
  localparam reg_sel_t  REG_RN = 2'b10;

  localparam wb_sel_t   WB_C      = 2'b00;
  localparam wb_sel_t   WB_SXIMM8 = 2'b10;
  localparam wb_sel_t   WB_MDATA  = 2'b11;

  typedef struct packed {
    logic [OPC_W-1:0] opcode;
    alu_op_t          alu_op;
    shift_op_t        shift_op;
    word_t            sximm5;
    word_t            sximm8;
    reg_idx_t         reg_idx;
  } decoded_t;

  typedef struct packed {
    wb_sel_t wb_sel;
    logic    w_en;
    logic    en_a;
    logic    en_b;
    logic    en_c;
    logic    sel_a; // A operand forced to zero
    logic    sel_b; // B operand is sximm5
  } dp_ctrl_t;

  typedef struct packed {
    logic ram_w_en;
    logic sel_addr; // address from pc
    logic load_pc;
    logic clear_pc; // pc takes start_pc
    logic load_addr;
    logic load_ir;
  } mem_ctrl_t;

  typedef enum logic [4:0] {
    S_RESET_PC,
    S_FETCH_ADDR,
    S_FETCH_IR,
    S_DECODE,
    S_WRITE_IMM,
    S_LOAD_A,
    S_LOAD_B,
    S_ALU,
    S_WRITE_C,
    S_ADDR_CALC,
    S_LOAD_DAR,
    S_MEM_READ,
    S_WRITE_MDATA,
    S_LOAD_B_ST,
    S_PASS_B,
    S_MEM_WRITE,
    S_HALT
  } ctrl_state_t;

endpackage

// File: datapath/alu.sv
`timescale 1ns/10ps

module alu (
  input  cpu_pkg::word_t     a,
  input  cpu_pkg::word_t     b,
  input  logic               use_imm,
  input  cpu_pkg::word_t     imm,
  input  cpu_pkg::shift_op_t shift_op,
  input  cpu_pkg::alu_op_t   alu_op,
  output cpu_pkg::word_t     result
);
  import cpu_pkg::*;

  word_t b_shifted;
  word_t b_val;

  always_comb begin
    case (shift_op)
      SH_LSL:  b_shifted = {b[WORD_W-2:0], 1'b0};
      SH_LSR:  b_shifted = {1'b0, b[WORD_W-1:1]};
      SH_ASR:  b_shifted = {b[WORD_W-1], b[WORD_W-1:1]}; // keeps sign
      default: b_shifted = b;
    endcase
  end

  assign b_val = use_imm ? imm : b_shifted;

  always_comb begin
    case (alu_op)
      ALU_AND: result = a & b_val;
      ALU_NOT: result = ~b_val;
      default: result = a + b_val; // add, also for mov and addresses
    endcase
  end

endmodule

// File: datapath/datapath.sv
`timescale 1ns/10ps

module datapath (
  input  logic              clk,
  input  logic              rst_n,
  input  cpu_pkg::dp_ctrl_t dp_ctrl,
  input  cpu_pkg::decoded_t dec,
  input  cpu_pkg::word_t    mdata,
  output cpu_pkg::word_t    c_out
);
  import cpu_pkg::*;

  word_t r_data;
  word_t w_data;
  word_t reg_a;
  word_t reg_b;
  word_t reg_c;
  word_t val_a;
  word_t alu_result;

  // writeback source
  always_comb begin
    case (dp_ctrl.wb_sel)
      WB_SXIMM8: w_data = dec.sximm8;
      WB_MDATA:  w_data = mdata;
      default:   w_data = reg_c;
    endcase
  end

  regfile rf_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .w_en   (dp_ctrl.w_en),
    .w_addr (dec.reg_idx),
    .w_data (w_data),
    .r_addr (dec.reg_idx),
    .r_data (r_data)
  );

  assign val_a = dp_ctrl.sel_a ? '0 : reg_a;

  alu alu_i (
    .a        (val_a),
    .b        (reg_b),
    .use_imm  (dp_ctrl.sel_b),
    .imm      (dec.sximm5),
    .shift_op (dec.shift_op),
    .alu_op   (dec.alu_op),
    .result   (alu_result)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reg_a <= '0;
      reg_b <= '0;
      reg_c <= '0;
    end else begin
      if (dp_ctrl.en_a) begin
        reg_a <= r_data;
      end
      if (dp_ctrl.en_b) begin
        reg_b <= r_data;
      end
      if (dp_ctrl.en_c) begin
        reg_c <= alu_result;
      end
    end
  end

  assign c_out = reg_c;

endmodule

// File: datapath/regfile.sv
`timescale 1ns/10ps

module regfile (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              w_en,
  input  cpu_pkg::reg_idx_t w_addr,
  input  cpu_pkg::word_t    w_data,
  input  cpu_pkg::reg_idx_t r_addr,
  output cpu_pkg::word_t    r_data
);
  import cpu_pkg::*;

  word_t regs [8]; // r0..r7

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 8; i++) begin
        regs[i] <= '0;
      end
    end else if (w_en) begin
      regs[w_addr] <= w_data;
    end
  end

  assign r_data = regs[r_addr]; // combinational read

endmodule

// File: project.f
+incdir+tb
common/cpu_pkg.sv
datapath/regfile.sv
datapath/alu.sv
datapath/datapath.sv
verilog/instr_decoder.sv
verilog/sequencer.sv
verilog/fetch_unit.sv
verilog/unified_ram.sv
verilog/cpu_top.sv
tb/cpu_tb.sv

// File: tb/ref_model.svh
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

localparam logic [2:0]  OPC_MOV   = 3'b110;
localparam logic [2:0]  OPC_ALU   = 3'b101;
localparam logic [2:0]  OPC_LDR   = 3'b011;
localparam logic [2:0]  OPC_STR   = 3'b100;
localparam logic [15:0] HALT_WORD = 16'hE000;

logic [15:0] m_mem [256]; // model copy of the unified memory
logic [15:0] m_reg [8];
logic [15:0] m_c;
logic [15:0] exp_cycles;  // reset release to halted, in clocks

function automatic int rand_below(input int n);
  return int'($unsigned($random(seed)) % n);
endfunction

function automatic logic [15:0] shift_word(input logic [15:0] v, input logic [1:0] sh);
  case (sh)
    2'b01:   return v << 1;
    2'b10:   return v >> 1;
    2'b11:   return {v[15], v[15:1]};
    default: return v;
  endcase
endfunction

function automatic logic [15:0] enc_reg(input logic [2:0] opc, input logic [1:0] op,
                                        input logic [2:0] rn, input logic [2:0] rd,
                                        input logic [1:0] sh, input logic [2:0] rm);
  return {opc, op, rn, rd, sh, rm};
endfunction

function automatic logic [15:0] enc_imm8(input logic [2:0] rn, input logic [7:0] imm8);
  return {OPC_MOV, 2'b10, rn, imm8};
endfunction

function automatic logic [15:0] enc_mem(input logic [2:0] opc, input logic [2:0] rn,
                                        input logic [2:0] rd, input logic [4:0] imm5);
  return {opc, 2'b00, rn, rd, imm5};
endfunction

// r7 = 0xff90..0xffef, so r7 + imm5 always lands in 0x80..0xfe
task automatic start_program();
  prog.delete();
  prog.push_back(enc_imm8(3'd7, 8'(144 + rand_below(96))));
  for (int r = 0; r < 7; r++) begin
    prog.push_back(enc_imm8(3'(r), 8'(rand_below(256))));
  end
endtask

task automatic add_random_instr(input int kinds);
  logic [2:0] rn;
  logic [2:0] rd;
  logic [2:0] rm;
  logic [1:0] sh;
  rn = 3'(rand_below(8));
  rd = 3'(rand_below(7)); // r7 is never a destination
  rm = 3'(rand_below(8));
  sh = 2'(rand_below(4));
  case (rand_below(kinds))
    0:       prog.push_back(enc_reg(OPC_ALU, 2'b00, rn, rd, sh, rm));
    1:       prog.push_back(enc_reg(OPC_ALU, 2'b10, rn, rd, sh, rm));
    2:       prog.push_back(enc_imm8(rd, 8'(rand_below(256))));
    3:       prog.push_back(enc_reg(OPC_MOV, 2'b00, 3'd0, rd, sh, rm));
    4:       prog.push_back(enc_reg(OPC_ALU, 2'b11, 3'd0, rd, sh, rm));
    5:       prog.push_back(enc_mem(OPC_LDR, 3'd7, rd, 5'(rand_below(32))));
    default: prog.push_back(enc_mem(OPC_STR, 3'd7, rm, 5'(rand_below(32))));
  endcase
endtask

task automatic build_memory(input logic [7:0] start);
  for (int i = 0; i < 256; i++) begin
    m_mem[i] = {8'(i) ^ 8'hA5, ~8'(i)};
  end
  for (int k = 0; k < prog.size(); k++) begin
    m_mem[8'(start + 8'(k))] = prog[k];
  end
endtask

task automatic model_execute(input logic [7:0] start);
  logic [7:0]  pc;
  logic [15:0] ir;
  logic [15:0] b;
  logic [15:0] addr;
  logic [2:0]  opc;
  logic [1:0]  op;
  logic [2:0]  rn;
  logic [2:0]  rd;
  bit          running;
  pc = start;
  running = 1'b1;
  exp_cycles = 16'd4; // leave reset, then fetch and decode the halt
  m_c = 16'h0000;
  for (int r = 0; r < 8; r++) begin
    m_reg[r] = 16'h0000;
  end
  for (int n = 0; n < 256 && running; n++) begin
    ir = m_mem[pc];
    pc = pc + 8'd1;
    {opc, op, rn, rd} = ir[15:5];
    b = shift_word(m_reg[ir[2:0]], ir[4:3]);
    addr = m_reg[rn] + {{11{ir[4]}}, ir[4:0]};
    case ({opc, op})
      {OPC_MOV, 2'b10}: begin
        m_reg[rn] = {{8{ir[7]}}, ir[7:0]}; // c untouched
        exp_cycles = exp_cycles + 16'd4;
      end
      {OPC_MOV, 2'b00}, {OPC_ALU, 2'b11}: begin
        m_c = (opc == OPC_MOV) ? b : ~b;
        m_reg[rd] = m_c;
        exp_cycles = exp_cycles + 16'd6;
      end
      {OPC_ALU, 2'b00}, {OPC_ALU, 2'b10}: begin
        m_c = (op == 2'b00) ? m_reg[rn] + b : m_reg[rn] & b;
        m_reg[rd] = m_c;
        exp_cycles = exp_cycles + 16'd7;
      end
      {OPC_LDR, 2'b00}: begin
        m_c = addr; // address stays in c
        m_reg[rd] = m_mem[addr[7:0]];
        exp_cycles = exp_cycles + 16'd8;
      end
      {OPC_STR, 2'b00}: begin
        m_c = m_reg[rd];
        m_mem[addr[7:0]] = m_c;
        exp_cycles = exp_cycles + 16'd9;
      end
      default: running = 1'b0; // halt and every unknown encoding
    endcase
  end
endtask

`endif

// File: tb/cpu_tb.sv
`timescale 1ns/10ps

module cpu_tb;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 3;
  localparam int HOLD_CYCLES  = 20;
  localparam int N_RANDOM     = 20;

  logic        clk = 1'b0;
  logic        rst_n;
  logic [7:0]  start_pc;
  logic [15:0] out;
  logic        halted;

  integer      seed = 34;
  logic [15:0] prog [$]; // program words starting at start_pc
  int          errors = 0;
  int          cycle_count = 0;
  int          armed_at = 0;
  bit          armed = 1'b0;
  int          budget = 0;
  int          prog_num = 0;

  `include "ref_model.svh"

  cpu_top #(
    .RAM_WORDS (256)
  ) dut_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .start_pc (start_pc),
    .out      (out),
    .halted   (halted)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // watchdog armed from reset release until halted
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (armed && (cycle_count - armed_at > budget)) begin
      $display("timeout: program %0d did not halt within %0d cycles", prog_num, budget);
      $display("TEST FAILED");
      $fatal(1, "watchdog expired");
    end
  end

  task automatic check_equal(input logic [15:0] actual, input logic [15:0] expected,
                             input string what);
    if (actual !== expected) begin
      errors++;
      $display("mismatch at %0t: %s, got %h, expected %h", $time, what, actual, expected);
      $display("TEST FAILED");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic run_program(input string name);
    logic [15:0] cycles;
    prog_num++;
    rst_n = 1'b0;
    start_pc = 8'(rand_below(128 - prog.size())); // code stays below the data region at 0x80
    build_memory(start_pc);
    for (int i = 0; i < 256; i++) begin
      dut_i.ram_i.mem[i] = m_mem[i];
    end
    model_execute(start_pc);
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    budget = 10 * prog.size() + 20;
    armed_at = cycle_count;
    armed = 1'b1;
    #1;
    check_equal(out, 16'h0000, {name, ": out after reset"});
    check_equal({15'd0, halted}, 16'h0000, {name, ": halted after reset"});
    cycles = 16'd0;
    while (!halted) begin
      @(posedge clk);
      #1;
      cycles = cycles + 16'd1;
    end
    armed = 1'b0;
    check_equal(cycles, exp_cycles, {name, ": cycles from reset release to halted"});
    check_equal(out, m_c, {name, ": out at halt"});
    repeat (HOLD_CYCLES) begin
      @(posedge clk);
      #1;
      check_equal(out, m_c, {name, ": out after halt"});
      check_equal({15'd0, halted}, 16'h0001, {name, ": halted level"});
    end
  endtask

  initial begin
    logic [4:0] imm5;
    rst_n = 1'b0;
    start_pc = 8'h00;
    @(posedge clk);
    #1;
    // each shift on a register move and then mvn
    for (int k = 0; k < 5; k++) begin
      start_program();
      if (k < 4) begin
        prog.push_back(enc_reg(OPC_MOV, 2'b00, 3'd0, 3'd2, 2'(k), 3'd1));
      end else begin
        prog.push_back(enc_reg(OPC_ALU, 2'b11, 3'd0, 3'd2, 2'(rand_below(4)), 3'd1));
      end
      prog.push_back(HALT_WORD);
      run_program("shift");
    end
    repeat (3) begin
      start_program();
      repeat (12) add_random_instr(3); // add, and, mov imm only
      prog.push_back(HALT_WORD);
      run_program("add_and");
    end
    repeat (2) begin
      start_program();
      imm5 = 5'(rand_below(32));
      prog.push_back(enc_mem(OPC_STR, 3'd7, 3'd1, imm5));
      prog.push_back(enc_mem(OPC_LDR, 3'd7, 3'd2, imm5));
      prog.push_back(enc_reg(OPC_MOV, 2'b00, 3'd0, 3'd3, 2'(rand_below(4)), 3'd2));
      prog.push_back(HALT_WORD);
      run_program("store_load");
    end
    repeat (N_RANDOM) begin
      start_program();
      repeat (4 + rand_below(13)) add_random_instr(7);
      prog.push_back(HALT_WORD);
      run_program("random");
    end
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: verilog/cpu_top.sv
`timescale 1ns/10ps

module cpu_top #(
  parameter int RAM_WORDS = 256
) (
  input  logic           clk,
  input  logic           rst_n,
  input  cpu_pkg::addr_t start_pc,
  output cpu_pkg::word_t out,
  output logic           halted
);
  import cpu_pkg::*;

  decoded_t  dec;
  dp_ctrl_t  dp_ctrl;
  mem_ctrl_t mem_ctrl;
  reg_sel_t  reg_sel;
  word_t     ir;
  word_t     ram_r_data;
  word_t     c_out;
  addr_t     ram_addr;

  assign out = c_out;

  instr_decoder decoder_i (
    .ir      (ir),
    .reg_sel (reg_sel),
    .dec     (dec)
  );

  sequencer seq_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .dec      (dec),
    .dp_ctrl  (dp_ctrl),
    .mem_ctrl (mem_ctrl),
    .reg_sel  (reg_sel),
    .halted   (halted)
  );

  fetch_unit fetch_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_pc   (start_pc),
    .mem_ctrl   (mem_ctrl),
    .ram_r_data (ram_r_data),
    .c_out      (c_out),
    .ir         (ir),
    .ram_addr   (ram_addr)
  );

  datapath dp_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .dp_ctrl (dp_ctrl),
    .dec     (dec),
    .mdata   (ram_r_data),
    .c_out   (c_out)
  );

  unified_ram #(
    .RAM_WORDS (RAM_WORDS)
  ) ram_i (
    .clk    (clk),
    .w_en   (mem_ctrl.ram_w_en),
    .addr   (ram_addr),
    .w_data (c_out), // stores always write register c
    .r_data (ram_r_data)
  );

endmodule

// File: verilog/fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit (
  input  logic               clk,
  input  logic               rst_n,
  input  cpu_pkg::addr_t     start_pc,
  input  cpu_pkg::mem_ctrl_t mem_ctrl,
  input  cpu_pkg::word_t     ram_r_data,
  input  cpu_pkg::word_t     c_out,
  output cpu_pkg::word_t     ir,
  output cpu_pkg::addr_t     ram_addr
);
  import cpu_pkg::*;

  addr_t pc;
  addr_t pc_next;
  addr_t dar; // data address register

  assign pc_next  = mem_ctrl.clear_pc ? start_pc : pc + addr_t'(1);
  assign ram_addr = mem_ctrl.sel_addr ? pc : dar;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc  <= '0;
      ir  <= '0;
      dar <= '0;
    end else begin
      if (mem_ctrl.load_pc) begin
        pc <= pc_next;
      end
      if (mem_ctrl.load_ir) begin
        ir <= ram_r_data;
      end
      if (mem_ctrl.load_addr) begin
        dar <= c_out[ADDR_W-1:0]; // low byte of computed address
      end
    end
  end

endmodule

// File: verilog/instr_decoder.sv
`timescale 1ns/10ps

module instr_decoder (
  input  cpu_pkg::word_t    ir,
  input  cpu_pkg::reg_sel_t reg_sel,
  output cpu_pkg::decoded_t dec
);
  import cpu_pkg::*;

  logic mem_format;

  // LDR and STR carry imm5 in bits 4:0, so there is no shift field there
  assign mem_format = (ir[15:13] == OPC_LDR) || (ir[15:13] == OPC_STR);

  always_comb begin
    dec.opcode   = ir[15:13];
    dec.alu_op   = ir[12:11];
    dec.shift_op = mem_format ? SH_NONE : ir[4:3];
    dec.sximm5   = {{(WORD_W-5){ir[4]}}, ir[4:0]};
    dec.sximm8   = {{(WORD_W-8){ir[7]}}, ir[7:0]};
    case (reg_sel)
      REG_RD:  dec.reg_idx = ir[7:5];
      REG_RN:  dec.reg_idx = ir[10:8];
      default: dec.reg_idx = ir[2:0]; // rm
    endcase
  end

endmodule

// File: verilog/sequencer.sv
`timescale 1ns/10ps

module sequencer (
  input  logic               clk,
  input  logic               rst_n,
  input  cpu_pkg::decoded_t  dec,
  output cpu_pkg::dp_ctrl_t  dp_ctrl,
  output cpu_pkg::mem_ctrl_t mem_ctrl,
  output cpu_pkg::reg_sel_t  reg_sel,
  output logic               halted
);
  import cpu_pkg::*;

  ctrl_state_t state;
  ctrl_state_t state_next;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= S_RESET_PC;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      S_RESET_PC:   state_next = S_FETCH_ADDR;
      S_FETCH_ADDR: state_next = S_FETCH_IR;
      S_FETCH_IR:   state_next = S_DECODE;
      S_DECODE: begin
        state_next = S_HALT; // anything unrecognised stops the core
        case (dec.opcode)
          OPC_MOV: begin
            if (dec.alu_op == OP_MOV_IMM) begin
              state_next = S_WRITE_IMM;
            end else if (dec.alu_op == ALU_ADD) begin
              state_next = S_LOAD_B;
            end
          end
          OPC_ALU: begin
            if (dec.alu_op == ALU_ADD || dec.alu_op == ALU_AND) begin
              state_next = S_LOAD_A;
            end else if (dec.alu_op == ALU_NOT) begin
              state_next = S_LOAD_B; // mvn
            end
          end
          OPC_LDR, OPC_STR: begin
            if (dec.alu_op == ALU_ADD) begin
              state_next = S_LOAD_A;
            end
          end
          default: state_next = S_HALT;
        endcase
      end
      S_LOAD_A:      state_next = (dec.opcode == OPC_ALU) ? S_LOAD_B : S_ADDR_CALC;
      S_LOAD_B:      state_next = S_ALU;
      S_ALU:         state_next = S_WRITE_C;
      S_ADDR_CALC:   state_next = S_LOAD_DAR;
      S_LOAD_DAR:    state_next = (dec.opcode == OPC_LDR) ? S_MEM_READ : S_LOAD_B_ST;
      S_MEM_READ:    state_next = S_WRITE_MDATA;
      S_LOAD_B_ST:   state_next = S_PASS_B;
      S_PASS_B:      state_next = S_MEM_WRITE;
      S_WRITE_IMM,
      S_WRITE_C,
      S_WRITE_MDATA,
      S_MEM_WRITE:   state_next = S_FETCH_ADDR; // instruction done
      S_HALT:        state_next = S_HALT;
      default:       state_next = S_RESET_PC;
    endcase
  end

  // control decode, one set of levels per state
  always_comb begin
    dp_ctrl  = '0;
    mem_ctrl = '0;
    reg_sel  = REG_RM;
    case (state)
      S_RESET_PC: begin
        mem_ctrl.load_pc  = 1'b1;
        mem_ctrl.clear_pc = 1'b1;
      end
      S_FETCH_ADDR: begin
        mem_ctrl.sel_addr = 1'b1;
      end
      S_FETCH_IR: begin
        mem_ctrl.sel_addr = 1'b1;
        mem_ctrl.load_ir  = 1'b1;
        mem_ctrl.load_pc  = 1'b1; // pc + 1
      end
      S_WRITE_IMM: begin
        reg_sel        = REG_RN;
        dp_ctrl.wb_sel = WB_SXIMM8;
        dp_ctrl.w_en   = 1'b1;
      end
      S_LOAD_A: begin
        reg_sel      = REG_RN;
        dp_ctrl.en_a = 1'b1;
      end
      S_LOAD_B: begin
        reg_sel      = REG_RM;
        dp_ctrl.en_b = 1'b1;
      end
      S_ALU: begin
        dp_ctrl.en_c  = 1'b1;
        dp_ctrl.sel_a = (dec.opcode == OPC_MOV); // mov is 0 + shifted rm
      end
      S_WRITE_C: begin
        reg_sel        = REG_RD;
        dp_ctrl.wb_sel = WB_C;
        dp_ctrl.w_en   = 1'b1;
      end
      S_ADDR_CALC: begin
        dp_ctrl.en_c  = 1'b1;
        dp_ctrl.sel_b = 1'b1; // rn + sximm5
      end
      S_LOAD_DAR: begin
        mem_ctrl.load_addr = 1'b1;
      end
      S_MEM_READ: begin
        mem_ctrl.sel_addr = 1'b0; // dar drives the ram
      end
      S_WRITE_MDATA: begin
        reg_sel        = REG_RD;
        dp_ctrl.wb_sel = WB_MDATA;
        dp_ctrl.w_en   = 1'b1;
      end
      S_LOAD_B_ST: begin
        reg_sel      = REG_RD;
        dp_ctrl.en_b = 1'b1;
      end
      S_PASS_B: begin
        dp_ctrl.en_c  = 1'b1;
        dp_ctrl.sel_a = 1'b1; // c = rd, becomes write data
      end
      S_MEM_WRITE: begin
        mem_ctrl.ram_w_en = 1'b1;
      end
      default: begin
        dp_ctrl  = '0;
        mem_ctrl = '0;
      end
    endcase
  end

  assign halted = (state == S_HALT);

endmodule

// File: verilog/unified_ram.sv
`timescale 1ns/10ps

module unified_ram #(
  parameter int RAM_WORDS = 256
) (
  input  logic           clk,
  input  logic           w_en,
  input  cpu_pkg::addr_t addr,
  input  cpu_pkg::word_t w_data,
  output cpu_pkg::word_t r_data
);
  import cpu_pkg::*;

  word_t mem [RAM_WORDS]; // program and data share this array

  always_ff @(posedge clk) begin
    if (w_en) begin
      mem[addr] <= w_data;
    end
    r_data <= mem[addr]; // read data one cycle after the address
  end

endmodule
